//--- src/itof_pkg.sv
`default_nettype none

package itof_pkg;

	// reorder-buffer tag
	localparam int rob_width = 4;

	// operand and result, int32 in and float32 out
	localparam int data_width = 32;

	// reservation station size
	localparam int n_entry = 2;

	// result queue depth, also the number of dispatch credits
	localparam int queue_depth = 3;

	// converter pipeline stages from disp_valid to conv_valid
	localparam int conv_latency = 2;

endpackage

`default_nettype wire

//--- src/itof_station.sv
`default_nettype none

module itof_station (
	input  logic clk,
	input  logic reset,
	input  logic issue_valid,
	output logic issue_ready,
	input  logic [itof_pkg::rob_width-1:0] issue_tag,
	input  logic opd_valid,
	input  logic [itof_pkg::rob_width-1:0] opd_tag,
	input  logic [itof_pkg::data_width-1:0] opd_data,
	input  logic gpr_cdb_valid,
	input  logic [itof_pkg::rob_width-1:0] gpr_cdb_tag,
	input  logic [itof_pkg::data_width-1:0] gpr_cdb_data,
	input  logic can_dispatch,
	output logic disp_valid,
	output logic [itof_pkg::rob_width-1:0] disp_tag,
	output logic [itof_pkg::data_width-1:0] disp_data
);
	// entries stay packed from 0, lower index is older
	logic [itof_pkg::n_entry-1:0] e_valid;
	logic [itof_pkg::n_entry-1:0] e_opd_valid;
	logic [itof_pkg::rob_width-1:0] e_tag [itof_pkg::n_entry];
	logic [itof_pkg::rob_width-1:0] e_opd_tag [itof_pkg::n_entry];
	logic [itof_pkg::data_width-1:0] e_opd_data [itof_pkg::n_entry];

	// after cdb wakeup
	logic [itof_pkg::n_entry-1:0] w_opd_valid;
	logic [itof_pkg::data_width-1:0] w_opd_data [itof_pkg::n_entry];

	logic [itof_pkg::n_entry-1:0] n_valid;
	logic [itof_pkg::n_entry-1:0] n_opd_valid;
	logic [itof_pkg::rob_width-1:0] n_tag [itof_pkg::n_entry];
	logic [itof_pkg::rob_width-1:0] n_opd_tag [itof_pkg::n_entry];
	logic [itof_pkg::data_width-1:0] n_opd_data [itof_pkg::n_entry];

	logic new_opd_valid;
	logic [itof_pkg::data_width-1:0] new_opd_data;
	logic [itof_pkg::n_entry-1:0] rdy;
	logic [$clog2(itof_pkg::n_entry)-1:0] sel;
	logic take;

	always_comb begin
		for (int i = 0; i < itof_pkg::n_entry; i++) begin
			w_opd_valid[i] = e_opd_valid[i] || (gpr_cdb_valid && gpr_cdb_tag == e_opd_tag[i]);
			w_opd_data[i] = e_opd_valid[i] ? e_opd_data[i] : gpr_cdb_data;
		end
	end

	// incoming op can catch a broadcast in its issue cycle
	assign new_opd_valid = opd_valid || (gpr_cdb_valid && gpr_cdb_tag == opd_tag);
	assign new_opd_data = opd_valid ? opd_data : gpr_cdb_data;

	assign rdy = e_valid & e_opd_valid; // stored state only, wakeup counts next cycle

	always_comb begin
		sel = '0;
		for (int i = itof_pkg::n_entry - 1; i >= 0; i--) begin
			if (rdy[i])
				sel = i[$clog2(itof_pkg::n_entry)-1:0]; // lowest ready wins
		end
	end

	assign disp_valid = can_dispatch && (|rdy);
	assign disp_tag = e_tag[sel];
	assign disp_data = e_opd_data[sel];

	assign issue_ready = !e_valid[itof_pkg::n_entry-1] || disp_valid;
	assign take = issue_valid && issue_ready;

	always_comb begin
		logic placed;
		placed = 1'b0;
		n_valid = e_valid;
		n_opd_valid = w_opd_valid;
		n_tag = e_tag;
		n_opd_tag = e_opd_tag;
		n_opd_data = w_opd_data;
		if (disp_valid) begin
			for (int i = 0; i < itof_pkg::n_entry - 1; i++) begin
				if (i >= sel) begin // close the gap
					n_valid[i] = e_valid[i+1];
					n_opd_valid[i] = w_opd_valid[i+1];
					n_tag[i] = e_tag[i+1];
					n_opd_tag[i] = e_opd_tag[i+1];
					n_opd_data[i] = w_opd_data[i+1];
				end
			end
			n_valid[itof_pkg::n_entry-1] = 1'b0;
		end
		for (int i = 0; i < itof_pkg::n_entry; i++) begin
			if (take && !placed && !n_valid[i]) begin // first free slot
				n_valid[i] = 1'b1;
				n_opd_valid[i] = new_opd_valid;
				n_tag[i] = issue_tag;
				n_opd_tag[i] = opd_tag;
				n_opd_data[i] = new_opd_data;
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			e_valid <= '0;
		else
			e_valid <= n_valid;
	end

	always_ff @(posedge clk) begin
		e_opd_valid <= n_opd_valid;
		e_tag <= n_tag;
		e_opd_tag <= n_opd_tag;
		e_opd_data <= n_opd_data;
	end

	// credit counter is the only thing allowed to open the gate
	a_disp_credit: assert property (@(posedge clk) disable iff (reset)
		!can_dispatch |-> !disp_valid);

endmodule

`default_nettype wire

//--- src/itof_convert.sv
`default_nettype none

module itof_convert (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic [itof_pkg::rob_width-1:0] in_tag,
	input  logic [itof_pkg::data_width-1:0] in_data,
	output logic out_valid,
	output logic [itof_pkg::rob_width-1:0] out_tag,
	output logic [itof_pkg::data_width-1:0] out_data
);
	logic [itof_pkg::data_width-1:0] mag;
	logic [$clog2(itof_pkg::data_width+1)-1:0] lz;

	logic s1_valid;
	logic [itof_pkg::rob_width-1:0] s1_tag;
	logic s1_sign;
	logic [itof_pkg::data_width-1:0] s1_mag;
	logic [$clog2(itof_pkg::data_width+1)-1:0] s1_lzc;

	logic [itof_pkg::data_width-1:0] norm;
	logic [7:0] exp_biased;
	logic guard;
	logic sticky;
	logic round_up;
	logic [30:0] rounded;

	// stage 1: sign, magnitude, leading zeros
	assign mag = in_data[31] ? -in_data : in_data; // 0x80000000 stays as 2^31

	always_comb begin
		lz = 6'd32;
		for (int i = 0; i < itof_pkg::data_width; i++) begin
			if (mag[i])
				lz = 6'(31 - i);
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		s1_tag <= in_tag;
		s1_sign <= in_data[31];
		s1_mag <= mag;
		s1_lzc <= lz;
	end

	// stage 2: normalize, round, pack
	assign norm = s1_mag << s1_lzc; // leading one now at bit 31
	assign exp_biased = 8'd158 - 8'(s1_lzc); // 127 + 31
	assign guard = norm[7];
	assign sticky = |norm[6:0];
	assign round_up = guard && (sticky || norm[8]); // ties go to even

	// carry out of the mantissa bumps the exponent
	assign rounded = {exp_biased, norm[30:8]} + 31'(round_up);

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= s1_valid;
	end

	always_ff @(posedge clk) begin
		out_tag <= s1_tag;
		if (s1_lzc == 6'd32)
			out_data <= '0; // +0.0
		else
			out_data <= {s1_sign, rounded};
	end

endmodule

`default_nettype wire

//--- src/itof_credit.sv
`default_nettype none

module itof_credit (
	input  logic clk,
	input  logic reset,
	input  logic dispatch,
	input  logic depart,
	output logic can_dispatch
);
	// results in the converter plus results in the queue
	logic [$clog2(itof_pkg::queue_depth+1)-1:0] count;

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (dispatch && !depart)
			count <= count + 1'b1;
		else if (depart && !dispatch)
			count <= count - 1'b1;
	end

	assign can_dispatch = count < itof_pkg::queue_depth;

	a_count_max: assert property (@(posedge clk) disable iff (reset)
		count <= itof_pkg::queue_depth);

	// a dispatched op holds its credit until it can reach the result port
	a_credit_held: assert property (@(posedge clk) disable iff (reset)
		dispatch |=> (count != 0) [*(itof_pkg::conv_latency + 1)]);

endmodule

`default_nettype wire

//--- src/result_queue.sv
`default_nettype none

module result_queue (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  logic [itof_pkg::rob_width-1:0] push_tag,
	input  logic [itof_pkg::data_width-1:0] push_data,
	output logic pop_valid,
	input  logic pop_ready,
	output logic [itof_pkg::rob_width-1:0] pop_tag,
	output logic [itof_pkg::data_width-1:0] pop_data
);
	logic [itof_pkg::rob_width-1:0] q_tag [itof_pkg::queue_depth];
	logic [itof_pkg::data_width-1:0] q_data [itof_pkg::queue_depth];
	logic [$clog2(itof_pkg::queue_depth)-1:0] wr_ptr;
	logic [$clog2(itof_pkg::queue_depth)-1:0] rd_ptr;
	logic [$clog2(itof_pkg::queue_depth+1)-1:0] count;
	logic pop;

	function automatic logic [$clog2(itof_pkg::queue_depth)-1:0] next_ptr(
		input logic [$clog2(itof_pkg::queue_depth)-1:0] p
	);
		if (p == itof_pkg::queue_depth - 1)
			return '0; // depth is not a power of two
		return p + 1'b1;
	endfunction

	assign pop_valid = count != 0;
	assign pop = pop_valid && pop_ready;
	assign pop_tag = q_tag[rd_ptr];
	assign pop_data = q_data[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			q_tag[wr_ptr] <= push_tag;
			q_data[wr_ptr] <= push_data;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> count < itof_pkg::queue_depth);

	a_hold_stall: assert property (@(posedge clk) disable iff (reset)
		pop_valid && !pop_ready |=> pop_valid && $stable(pop_tag) && $stable(pop_data));

endmodule

`default_nettype wire

//--- src/itof_unit.sv
`default_nettype none

module itof_unit (
	input  logic clk,
	input  logic reset,
	input  logic issue_valid,
	output logic issue_ready,
	input  logic [itof_pkg::rob_width-1:0] issue_tag,
	input  logic opd_valid,
	input  logic [itof_pkg::rob_width-1:0] opd_tag,
	input  logic [itof_pkg::data_width-1:0] opd_data,
	input  logic gpr_cdb_valid,
	input  logic [itof_pkg::rob_width-1:0] gpr_cdb_tag,
	input  logic [itof_pkg::data_width-1:0] gpr_cdb_data,
	output logic cdb_valid,
	input  logic cdb_ready,
	output logic [itof_pkg::rob_width-1:0] cdb_tag,
	output logic [itof_pkg::data_width-1:0] cdb_data
);
	logic can_dispatch;
	logic disp_valid;
	logic [itof_pkg::rob_width-1:0] disp_tag;
	logic [itof_pkg::data_width-1:0] disp_data;
	logic conv_valid;
	logic [itof_pkg::rob_width-1:0] conv_tag;
	logic [itof_pkg::data_width-1:0] conv_data;
	logic cdb_fire;

	assign cdb_fire = cdb_valid && cdb_ready; // frees a credit

	itof_station u_station (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_tag(issue_tag),
		.opd_valid(opd_valid),
		.opd_tag(opd_tag),
		.opd_data(opd_data),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_tag(gpr_cdb_tag),
		.gpr_cdb_data(gpr_cdb_data),
		.can_dispatch(can_dispatch),
		.disp_valid(disp_valid),
		.disp_tag(disp_tag),
		.disp_data(disp_data)
	);

	itof_credit u_credit (
		.clk(clk),
		.reset(reset),
		.dispatch(disp_valid),
		.depart(cdb_fire),
		.can_dispatch(can_dispatch)
	);

	itof_convert u_convert (
		.clk(clk),
		.reset(reset),
		.in_valid(disp_valid),
		.in_tag(disp_tag),
		.in_data(disp_data),
		.out_valid(conv_valid),
		.out_tag(conv_tag),
		.out_data(conv_data)
	);

	result_queue u_queue (
		.clk(clk),
		.reset(reset),
		.push(conv_valid), // room guaranteed by credits
		.push_tag(conv_tag),
		.push_data(conv_data),
		.pop_valid(cdb_valid),
		.pop_ready(cdb_ready),
		.pop_tag(cdb_tag),
		.pop_data(cdb_data)
	);

endmodule

`default_nettype wire

//--- test/itof_ref.svh
`ifndef ITOF_REF_SVH
`define ITOF_REF_SVH

// signed int32 to IEEE-754 single, round to nearest even
function automatic logic [31:0] ref_itof(input logic [31:0] v);
	logic [31:0] m;
	logic [31:0] mant;
	logic [31:0] rem;
	logic [31:0] half;
	int msb;
	int sh;
	if (v == 32'd0)
		return 32'd0;
	m = v[31] ? (~v + 32'd1) : v;
	msb = 0;
	for (int i = 0; i < 32; i++) begin
		if (m[i])
			msb = i;
	end
	if (msb <= 23) begin
		mant = m << (23 - msb); // exact, no rounding
	end else begin
		sh = msb - 23;
		mant = m >> sh;
		rem = m & ((32'd1 << sh) - 32'd1);
		half = 32'd1 << (sh - 1);
		if (rem > half || (rem == half && mant[0]))
			mant = mant + 32'd1;
		if (mant[24]) begin // rounded up to the next power of two
			mant = mant >> 1;
			msb++;
		end
	end
	return {v[31], 8'(msb + 127), mant[22:0]};
endfunction

function automatic logic [itof_pkg::rob_width+31:0] pack_result(
	input logic [itof_pkg::rob_width-1:0] tag,
	input logic [31:0] value
);
	return {tag, value};
endfunction

`endif

//--- test/itof_unit_tb.sv
`default_nettype none

module itof_unit_tb;

	logic clk;
	logic reset;
	logic issue_valid;
	logic issue_ready;
	logic [itof_pkg::rob_width-1:0] issue_tag;
	logic opd_valid;
	logic [itof_pkg::rob_width-1:0] opd_tag;
	logic [itof_pkg::data_width-1:0] opd_data;
	logic gpr_cdb_valid;
	logic [itof_pkg::rob_width-1:0] gpr_cdb_tag;
	logic [itof_pkg::data_width-1:0] gpr_cdb_data;
	logic cdb_valid;
	logic cdb_ready;
	logic [itof_pkg::rob_width-1:0] cdb_tag;
	logic [itof_pkg::data_width-1:0] cdb_data;

	// scoreboard, indexed by issue tag
	logic outstanding [2**itof_pkg::rob_width];
	logic wait_prod [2**itof_pkg::rob_width];
	logic [31:0] operand [2**itof_pkg::rob_width];
	logic [itof_pkg::rob_width-1:0] prod_of [2**itof_pkg::rob_width];
	// integer producers, indexed by gpr tag
	logic prod_busy [2**itof_pkg::rob_width];
	logic armed [2**itof_pkg::rob_width];
	logic [31:0] prod_value [2**itof_pkg::rob_width];
	int n_out;

	logic auto_bcast;
	logic rand_ready;
	logic stalled;
	logic [itof_pkg::rob_width-1:0] held_tag;
	logic [31:0] held_data;

	`include "itof_ref.svh"

	itof_unit dut_i (
		.clk(clk),
		.reset(reset),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_tag(issue_tag),
		.opd_valid(opd_valid),
		.opd_tag(opd_tag),
		.opd_data(opd_data),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_tag(gpr_cdb_tag),
		.gpr_cdb_data(gpr_cdb_data),
		.cdb_valid(cdb_valid),
		.cdb_ready(cdb_ready),
		.cdb_tag(cdb_tag),
		.cdb_data(cdb_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
			abort_run($sformatf("Mismatch at time %0t: %s expected %h, got %h",
				$time, name, expected, actual));
	endtask

	function automatic logic [31:0] random_operand();
		case ($urandom % 4)
			0: return $urandom;
			1: return 32'($urandom % 512) - 32'd256;
			2: return (32'h0100_0001 | (32'($urandom % 2) << 1)) << ($urandom % 7); // ties
			default: return -(32'd1 << ($urandom % 32));
		endcase
	endfunction

	task automatic pick_free_tag(output logic [itof_pkg::rob_width-1:0] tag);
		logic [itof_pkg::rob_width-1:0] t;
		t = itof_pkg::rob_width'($urandom);
		for (int k = 0; k < 2**itof_pkg::rob_width; k++) begin
			if (!outstanding[t]) begin
				tag = t;
				return;
			end
			t = t + 1'b1;
		end
		abort_run("no free issue tag left");
	endtask

	task automatic pick_free_producer(output logic [itof_pkg::rob_width-1:0] p);
		logic [itof_pkg::rob_width-1:0] t;
		t = itof_pkg::rob_width'($urandom);
		for (int k = 0; k < 2**itof_pkg::rob_width; k++) begin
			if (!prod_busy[t] && !(gpr_cdb_valid && gpr_cdb_tag == t)) begin // not on the bus
				p = t;
				return;
			end
			t = t + 1'b1;
		end
		abort_run("no free producer tag left");
	endtask

	// drives one gpr broadcast and wakes the scoreboard entries
	task automatic release_producer(input logic [itof_pkg::rob_width-1:0] p);
		gpr_cdb_valid = 1'b1;
		gpr_cdb_tag = p;
		gpr_cdb_data = prod_value[p];
		for (int i = 0; i < 2**itof_pkg::rob_width; i++) begin
			if (outstanding[i] && wait_prod[i] && prod_of[i] == p)
				wait_prod[i] = 1'b0;
		end
		prod_busy[p] = 1'b0;
		armed[p] = 1'b0;
	endtask

	task automatic broadcast(input logic [itof_pkg::rob_width-1:0] p);
		release_producer(p);
		@(posedge clk);
		#1;
		gpr_cdb_valid = 1'b0;
	endtask

	task automatic issue_op(input logic [itof_pkg::rob_width-1:0] tag, input logic ready,
		input logic [31:0] value, input logic same_cycle);
		logic [itof_pkg::rob_width-1:0] p;
		int t;
		p = '0;
		if (!ready) begin
			pick_free_producer(p);
			prod_busy[p] = 1'b1;
			prod_value[p] = value;
		end
		issue_valid = 1'b1;
		issue_tag = tag;
		opd_valid = ready;
		opd_tag = p;
		opd_data = ready ? value : $urandom;
		if (same_cycle) begin // broadcast lands in the issue cycle
			gpr_cdb_valid = 1'b1;
			gpr_cdb_tag = p;
			gpr_cdb_data = value;
		end
		t = 0;
		@(negedge clk);
		while (!issue_ready) begin
			t++;
			if (t > 200)
				abort_run("timeout waiting for issue_ready");
			@(negedge clk);
		end
		outstanding[tag] = 1'b1;
		operand[tag] = value;
		prod_of[tag] = p;
		wait_prod[tag] = !ready && !same_cycle;
		n_out++;
		if (!ready && !same_cycle)
			armed[p] = 1'b1;
		else if (!ready)
			prod_busy[p] = 1'b0;
		@(posedge clk);
		#1;
		issue_valid = 1'b0;
		if (same_cycle)
			gpr_cdb_valid = 1'b0;
	endtask

	task automatic wait_tag_done(input logic [itof_pkg::rob_width-1:0] tag, input int limit);
		int t;
		t = 0;
		while (outstanding[tag]) begin
			if (t == limit)
				abort_run($sformatf("timeout waiting for the result of tag %0d", tag));
			@(posedge clk);
			#1;
			t++;
		end
	endtask

	task automatic wait_all_done(input int limit);
		int t;
		t = 0;
		while (n_out != 0) begin
			if (t == limit)
				abort_run($sformatf("timeout waiting for %0d outstanding results", n_out));
			@(posedge clk);
			#1;
			t++;
		end
	endtask

	always @(posedge clk) begin
		#1;
		if (rand_ready)
			cdb_ready = ($urandom % 4) != 0;
	end

	always @(posedge clk) begin : bcast_driver
		logic [itof_pkg::rob_width-1:0] p;
		logic found;
		#1;
		if (auto_bcast) begin
			gpr_cdb_valid = 1'b0;
			found = 1'b0;
			p = itof_pkg::rob_width'($urandom);
			if ($urandom % 3 == 0) begin
				for (int k = 0; k < 2**itof_pkg::rob_width; k++) begin
					if (!found && armed[p])
						found = 1'b1;
					else if (!found)
						p = p + 1'b1;
				end
			end
			if (found)
				release_producer(p);
		end
	end

	// result port checker, sampled mid-cycle
	always @(negedge clk) begin
		if (!reset) begin
			if (stalled) begin
				check_value("cdb_valid", 1, cdb_valid);
				check_value("cdb_tag", held_tag, cdb_tag);
				check_value("cdb_data", held_data, cdb_data);
			end
			if (cdb_valid && cdb_ready) begin
				if (!outstanding[cdb_tag])
					abort_run($sformatf("result for tag %0d which is not outstanding", cdb_tag));
				if (wait_prod[cdb_tag])
					abort_run($sformatf("result for tag %0d before its operand was broadcast",
						cdb_tag));
				check_value("cdb_tag/cdb_data", pack_result(cdb_tag, ref_itof(operand[cdb_tag])),
					pack_result(cdb_tag, cdb_data));
				outstanding[cdb_tag] = 1'b0;
				n_out--;
			end
			stalled = cdb_valid && !cdb_ready;
			held_tag = cdb_tag;
			held_data = cdb_data;
		end
	end

	initial begin
		logic [itof_pkg::rob_width-1:0] a;
		logic [itof_pkg::rob_width-1:0] b;
		logic [31:0] vals [$];
		int n;
		int k;
		void'($urandom(32'h8361));
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_tag = '0;
		opd_valid = 1'b0;
		opd_tag = '0;
		opd_data = '0;
		gpr_cdb_valid = 1'b0;
		gpr_cdb_tag = '0;
		gpr_cdb_data = '0;
		cdb_ready = 1'b1;
		auto_bcast = 1'b0;
		rand_ready = 1'b0;
		stalled = 1'b0;
		held_tag = '0;
		held_data = '0;
		n_out = 0;
		for (int i = 0; i < 2**itof_pkg::rob_width; i++) begin
			outstanding[i] = 1'b0;
			wait_prod[i] = 1'b0;
			prod_busy[i] = 1'b0;
			armed[i] = 1'b0;
		end
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		check_value("issue_ready", 1, issue_ready);
		check_value("cdb_valid", 0, cdb_valid);
		@(posedge clk);
		#1;

		vals = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h0100_0000,
			32'h4000_0000, 32'h0100_0001, 32'h0100_0003, 32'hfeff_fffd, 32'h00ff_ffff,
			32'd123456789, 32'hffff_fff9, 32'h0000_0100};
		foreach (vals[i]) begin
			pick_free_tag(a);
			issue_op(a, 1'b1, vals[i], 1'b0);
			wait_all_done(20);
		end

		// operand waits for a later broadcast
		pick_free_tag(a);
		issue_op(a, 1'b0, 32'hfff0_0001, 1'b0);
		repeat (10) @(posedge clk);
		#1;
		broadcast(prod_of[a]);
		wait_all_done(20);

		pick_free_tag(a);
		issue_op(a, 1'b0, 32'h0123_4567, 1'b1);
		wait_all_done(20);

		// younger ready op overtakes an older waiting one
		pick_free_tag(a);
		issue_op(a, 1'b0, -32'd100, 1'b0);
		pick_free_tag(b);
		issue_op(b, 1'b1, 32'd77777777, 1'b0);
		wait_tag_done(b, 20);
		broadcast(prod_of[a]);
		wait_all_done(20);

		// back-pressure until the station fills
		cdb_ready = 1'b0;
		n = 0;
		@(negedge clk);
		while (issue_ready) begin
			if (n == 8)
				abort_run("issue_ready stayed high while cdb_ready was held low");
			@(posedge clk);
			#1;
			pick_free_tag(a);
			issue_op(a, 1'b1, random_operand(), 1'b0);
			n++;
			@(negedge clk);
		end
		repeat (12) @(posedge clk);
		#1;
		cdb_ready = 1'b1;
		wait_all_done(40);

		rand_ready = 1'b1;
		auto_bcast = 1'b1;
		repeat (300) begin
			pick_free_tag(a);
			issue_op(a, 1'($urandom), random_operand(), 1'b0);
			k = $urandom % 3;
			repeat (k) begin
				@(posedge clk);
				#1;
			end
		end
		wait_all_done(3000);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
src/itof_pkg.sv
src/itof_station.sv
src/itof_convert.sv
src/itof_credit.sv
src/result_queue.sv
src/itof_unit.sv
+incdir+test
test/itof_unit_tb.sv

//--- Bender.yml
package:
  name: itof_unit

sources:
  - files:
      - src/itof_pkg.sv
      - src/itof_station.sv
      - src/itof_convert.sv
      - src/itof_credit.sv
      - src/result_queue.sv
      - src/itof_unit.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/itof_unit_tb.sv
